// File: sim.f
sld_pkg.sv
sld_stage_reg.sv
sld_ctrl.sv
sld_operand.sv
sld_align.sv
sld_writeback.sv
sld_unit.sv
sld_properties.sv
tb_sld.sv

// File: tb_sld.sv
// slide unit testbench
// directed slides against a register file model and a reference slide model

`timescale 1ns/1ps

module tb_sld;

    import sld_pkg::*;

    localparam int unsigned CLK_PERIOD = 40;
    localparam int unsigned TIMEOUT    = 50;

    logic                clk_i = 1'b0;
    logic                async_rst_ni;
    logic                op_rdy_i;
    logic                op_ack_o;
    sld_op_e             mode_i;
    vsew_e               vsew_i;
    logic [CFG_VL_W-1:0] vl_i;
    logic                masked_i;
    logic [31:0]         rs1_i;
    logic [4:0]          vs2_i;
    logic [4:0]          vd_i;
    logic [4:0]          vreg_rd_addr_o;
    logic [VREG_W-1:0]   vreg_rd_i;
    logic [VMSK_W-1:0]   vreg_mask_i;
    logic                vreg_wr_en_o;
    logic [4:0]          vreg_wr_addr_o;
    logic [VREG_W-1:0]   vreg_wr_o;
    logic [VMSK_W-1:0]   vreg_wr_mask_o;

    // register file model with v0 as the element mask
    logic [VREG_W-1:0]   regs [32];
    logic [4:0]          wr_addr_q [$];
    logic [VREG_W-1:0]   wr_data_q [$];
    logic [VMSK_W-1:0]   wr_mask_q [$];
    logic [31:0]         lfsr = 32'hca02;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    assign vreg_rd_i   = regs[vreg_rd_addr_o];
    assign vreg_mask_i = regs[0][VMSK_W-1:0];

    sld_unit sld_unit_i (.*);

    // record each write and apply it to the model
    always @(negedge clk_i) begin
        if (vreg_wr_en_o === 1'b1) begin
            wr_addr_q.push_back(vreg_wr_addr_o);
            wr_data_q.push_back(vreg_wr_o);
            wr_mask_q.push_back(vreg_wr_mask_o);
            for (int b = 0; b < VMSK_W; b++) begin
                if (vreg_wr_mask_o[b]) begin
                    regs[vreg_wr_addr_o][b*8 +: 8] = vreg_wr_o[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // random source and reference model

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_vreg(output logic [VREG_W-1:0] v);
        for (int k = 0; k < VREG_W; k++) begin
            v[k] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [VREG_W-1:0] byte_bits(logic [VMSK_W-1:0] m);
        logic [VREG_W-1:0] bits;
        for (int b = 0; b < VMSK_W; b++) begin
            bits[b*8 +: 8] = {8{m[b]}};
        end
        return bits;
    endfunction

    // slide up reads vs2[i-rs1] and slide down reads vs2[i+rs1] or zero
    function automatic void slide_ref(input sld_op_e mode, input vsew_e sew, input int vl,
                                      input logic masked, input logic [31:0] rs1,
                                      input logic [VREG_W-1:0] src, input logic [VMSK_W-1:0] v0,
                                      output logic [VREG_W-1:0] data,
                                      output logic [VMSK_W-1:0] mask);
        int     eb;
        int     nelem;
        longint idx;
        eb    = 1 << sew;
        nelem = VMSK_W / eb;
        data  = '0;
        mask  = '0;
        for (int i = 0; i < nelem; i++) begin
            if (mode == SLD_UP) begin
                idx = longint'(i) - longint'(rs1);
            end else begin
                idx = longint'(i) + longint'(rs1);
            end
            if (i < vl && (!masked || v0[i]) && (mode == SLD_DOWN || idx >= 0)) begin
                for (int b = 0; b < eb; b++) begin
                    mask[i*eb + b] = 1'b1;
                    if (idx >= 0 && idx < nelem) begin
                        data[(i*eb + b)*8 +: 8] = src[(int'(idx)*eb + b)*8 +: 8];
                    end
                end
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [VREG_W-1:0] got,
                              input logic [VREG_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_mask(input string name, input logic [VMSK_W-1:0] got,
                              input logic [VMSK_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // command and write handling

    // starts on a falling edge and returns on the falling edge after the accept
    task automatic issue_cmd(input sld_op_e mode, input vsew_e sew, input int vl,
                             input logic masked, input logic [31:0] rs1,
                             input logic [4:0] vs2, input logic [4:0] vd, input logic hold);
        int cnt;
        mode_i   = mode;
        vsew_i   = sew;
        vl_i     = CFG_VL_W'(vl);
        masked_i = masked;
        rs1_i    = rs1;
        vs2_i    = vs2;
        vd_i     = vd;
        op_rdy_i = 1'b1;
        cnt      = 0;
        #(CLK_PERIOD / 4);
        while (op_ack_o !== 1'b1) begin
            if (cnt == TIMEOUT) begin
                fail_run("timeout while waiting for the command to be accepted");
            end
            @(negedge clk_i);
            #(CLK_PERIOD / 4);
            cnt++;
        end
        @(negedge clk_i);
        op_rdy_i = hold;
    endtask

    task automatic wait_writes(input int n);
        int cnt;
        cnt = 0;
        while (wr_addr_q.size() < n) begin
            if (cnt == TIMEOUT) begin
                fail_run("timeout while waiting for the register write");
            end
            @(negedge clk_i);
            cnt++;
        end
    endtask

    task automatic check_write(input logic [4:0] vd, input logic [VREG_W-1:0] exp_data,
                               input logic [VMSK_W-1:0] exp_mask);
        logic [VREG_W-1:0] data;
        logic [VMSK_W-1:0] mask;
        check_addr("vreg_wr_addr_o", wr_addr_q.pop_front(), vd);
        data = wr_data_q.pop_front();
        mask = wr_mask_q.pop_front();
        check_mask("vreg_wr_mask_o", mask, exp_mask);
        check_data("vreg_wr_o", data & byte_bits(exp_mask), exp_data & byte_bits(exp_mask));
    endtask

    // single command from v2 into v3
    task automatic slide_test(input sld_op_e mode, input vsew_e sew, input int vl,
                              input logic masked, input logic [31:0] rs1);
        logic [VREG_W-1:0] exp_data;
        logic [VMSK_W-1:0] exp_mask;
        slide_ref(mode, sew, vl, masked, rs1, regs[2], regs[0][VMSK_W-1:0], exp_data, exp_mask);
        issue_cmd(mode, sew, vl, masked, rs1, 5'd2, 5'd3, 1'b0);
        wait_writes(1);
        check_write(5'd3, exp_data, exp_mask);
    endtask

    task automatic back_to_back_test();
        logic [VREG_W-1:0] data_a;
        logic [VREG_W-1:0] data_b;
        logic [VMSK_W-1:0] mask_a;
        logic [VMSK_W-1:0] mask_b;
        slide_ref(SLD_UP, VSEW_16, 8, 1'b0, 3, regs[4], '0, data_a, mask_a);
        slide_ref(SLD_DOWN, VSEW_8, 16, 1'b0, 5, regs[6], '0, data_b, mask_b);
        issue_cmd(SLD_UP, VSEW_16, 8, 1'b0, 3, 5'd4, 5'd5, 1'b1);
        issue_cmd(SLD_DOWN, VSEW_8, 16, 1'b0, 5, 5'd6, 5'd7, 1'b0);
        wait_writes(2);
        check_write(5'd5, data_a, mask_a);
        check_write(5'd7, data_b, mask_b);
    endtask

    initial begin
        logic [VREG_W-1:0] v;
        vsew_e             sews [3];
        int                nelem;
        int                per_chunk;
        sews         = '{VSEW_8, VSEW_16, VSEW_32};
        async_rst_ni = 1'b0;
        op_rdy_i     = 1'b0;
        mode_i       = SLD_UP;
        vsew_i       = VSEW_8;
        vl_i         = '0;
        masked_i     = 1'b0;
        rs1_i        = '0;
        vs2_i        = '0;
        vd_i         = '0;
        for (int r = 0; r < 32; r++) begin
            rand_vreg(v);
            regs[r] = v;
        end
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        async_rst_ni = 1'b1;
        @(negedge clk_i);

        // full vl slides at each element width
        for (int s = 0; s < 3; s++) begin
            nelem     = VMSK_W >> sews[s];
            per_chunk = CHUNK_B >> sews[s];
            slide_test(SLD_UP, sews[s], nelem, 1'b0, 0);
            slide_test(SLD_UP, sews[s], nelem, 1'b0, 1);
            slide_test(SLD_UP, sews[s], nelem, 1'b0, per_chunk + 1);
            slide_test(SLD_DOWN, sews[s], nelem, 1'b0, 1);
            slide_test(SLD_DOWN, sews[s], nelem, 1'b0, per_chunk + 1);
            slide_test(SLD_DOWN, sews[s], nelem, 1'b0, nelem - 1);
        end

        // short and zero vl
        slide_test(SLD_UP, VSEW_8, 5, 1'b0, 2);
        slide_test(SLD_DOWN, VSEW_16, 3, 1'b0, 1);
        slide_test(SLD_UP, VSEW_32, 0, 1'b0, 0);
        slide_test(SLD_DOWN, VSEW_8, 0, 1'b0, 3);

        // masked slides with a random v0
        rand_vreg(v);
        regs[0] = v;
        slide_test(SLD_UP, VSEW_8, 16, 1'b1, 3);
        slide_test(SLD_DOWN, VSEW_16, 8, 1'b1, 2);
        slide_test(SLD_UP, VSEW_32, 4, 1'b1, 1);

        // slide amount at or beyond VLMAX
        slide_test(SLD_UP, VSEW_8, 16, 1'b0, 16);
        slide_test(SLD_DOWN, VSEW_32, 4, 1'b0, 7);
        slide_test(SLD_DOWN, VSEW_16, 6, 1'b0, 32'hffff_ffff);

        back_to_back_test();

        if (sld_unit_i.props_i.err_cnt != 0) begin
            fail_run("the bound checker saw a property violation");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// File: sld_properties.sv
// slide unit properties
// command handshake and write port checks, bound into the top level

`timescale 1ns/1ps

module sld_properties (
    input logic                        clk_i,
    input logic                        async_rst_ni,
    input logic                        op_rdy_i,
    input logic                        op_ack_o,
    input logic [4:0]                  vreg_rd_addr_o,
    input logic                        vreg_wr_en_o,
    input logic [4:0]                  vreg_wr_addr_o,
    input logic [sld_pkg::VREG_W-1:0]  vreg_wr_o,
    input logic [sld_pkg::VMSK_W-1:0]  vreg_wr_mask_o
);

    // number of property violations so far
    int unsigned err_cnt = 0;

    ack_needs_rdy: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        op_ack_o |-> op_rdy_i)
        else begin
            $error("op_ack_o high while op_rdy_i is low");
            err_cnt++;
        end

    // a write lasts a single cycle
    wr_single_cycle: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        vreg_wr_en_o |=> !vreg_wr_en_o)
        else begin
            $error("vreg_wr_en_o held for more than one cycle");
            err_cnt++;
        end

    mask_idle_zero: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        !vreg_wr_en_o |-> (vreg_wr_mask_o == '0))
        else begin
            $error("vreg_wr_mask_o set without a write");
            err_cnt++;
        end

    ctrl_known: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        !$isunknown({op_ack_o, vreg_wr_en_o, vreg_wr_mask_o, vreg_rd_addr_o}))
        else begin
            $error("unknown value on a control output");
            err_cnt++;
        end

    // address and data only matter while writing
    wr_known: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        vreg_wr_en_o |-> !$isunknown({vreg_wr_addr_o, vreg_wr_o}))
        else begin
            $error("unknown write address or data");
            err_cnt++;
        end

endmodule

bind sld_unit sld_properties props_i (.*);

// File: sld_unit.sv
// vector slide unit top level
// control, read stage, operand, alignment and writeback pipeline

`timescale 1ns/1ps

module sld_unit (
    input  logic                          clk_i,
    input  logic                          async_rst_ni,
    input  logic                          op_rdy_i,
    output logic                          op_ack_o,
    input  sld_pkg::sld_op_e              mode_i,
    input  sld_pkg::vsew_e                vsew_i,
    input  logic [sld_pkg::CFG_VL_W-1:0]  vl_i,
    input  logic                          masked_i,
    input  logic [31:0]                   rs1_i,
    input  logic [4:0]                    vs2_i,
    input  logic [4:0]                    vd_i,
    output logic [4:0]                    vreg_rd_addr_o,
    input  logic [sld_pkg::VREG_W-1:0]    vreg_rd_i,
    input  logic [sld_pkg::VMSK_W-1:0]    vreg_mask_i,
    output logic                          vreg_wr_en_o,
    output logic [4:0]                    vreg_wr_addr_o,
    output logic [sld_pkg::VREG_W-1:0]    vreg_wr_o,
    output logic [sld_pkg::VMSK_W-1:0]    vreg_wr_mask_o
);

    import sld_pkg::*;

    logic                ctrl_valid, ctrl_ready;
    sld_token_t          ctrl_tok;
    logic                rd_valid, rd_ready;
    sld_token_t          rd_tok;
    logic                op_valid, op_ready;
    sld_token_t          op_tok;
    logic [SLD_OP_W-1:0] op_low, op_high;
    logic [VMSK_W-1:0]   v0msk;
    logic                res_valid, res_ready;
    sld_token_t          res_tok;
    logic [SLD_OP_W-1:0] result;
    logic [CHUNK_B-1:0]  result_mask;

    ////////////////////////////////////////////////////////////////////////////
    // command control and register read stage

    sld_ctrl ctrl_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_rdy_i       (op_rdy_i),
        .op_ack_o       (op_ack_o),
        .mode_i         (mode_i),
        .vsew_i         (vsew_i),
        .vl_i           (vl_i),
        .masked_i       (masked_i),
        .rs1_i          (rs1_i),
        .vs2_i          (vs2_i),
        .vd_i           (vd_i),
        .tok_valid_o    (ctrl_valid),
        .tok_ready_i    (ctrl_ready),
        .tok_o          (ctrl_tok),
        .vreg_rd_addr_o (vreg_rd_addr_o)
    );

    sld_stage_reg #(
        .payload_t (sld_token_t)
    ) rd_stage_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (ctrl_valid),
        .ready_o      (ctrl_ready),
        .data_i       (ctrl_tok),
        .valid_o      (rd_valid),
        .ready_i      (rd_ready),
        .data_o       (rd_tok)
    );

    ////////////////////////////////////////////////////////////////////////////
    // operands, alignment and writeback

    sld_operand operand_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .tok_valid_i  (rd_valid),
        .tok_ready_o  (rd_ready),
        .tok_i        (rd_tok),
        .vreg_rd_i    (vreg_rd_i),
        .vreg_mask_i  (vreg_mask_i),
        .op_valid_o   (op_valid),
        .op_ready_i   (op_ready),
        .tok_o        (op_tok),
        .op_low_o     (op_low),
        .op_high_o    (op_high),
        .v0msk_o      (v0msk)
    );

    sld_align align_i (
        .clk_i         (clk_i),
        .async_rst_ni  (async_rst_ni),
        .op_valid_i    (op_valid),
        .op_ready_o    (op_ready),
        .tok_i         (op_tok),
        .op_low_i      (op_low),
        .op_high_i     (op_high),
        .res_valid_o   (res_valid),
        .res_ready_i   (res_ready),
        .tok_o         (res_tok),
        .result_o      (result),
        .result_mask_o (result_mask)
    );

    sld_writeback writeback_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .res_valid_i    (res_valid),
        .res_ready_o    (res_ready),
        .tok_i          (res_tok),
        .result_i       (result),
        .result_mask_i  (result_mask),
        .v0msk_i        (v0msk),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_o      (vreg_wr_o),
        .vreg_wr_mask_o (vreg_wr_mask_o)
    );

endmodule

// File: sld_writeback.sv
// slide writeback
// collects result chunks, applies vl and v0 masks, writes the destination once

`timescale 1ns/1ps

module sld_writeback (
    input  logic                          clk_i,
    input  logic                          async_rst_ni,
    input  logic                          res_valid_i,
    output logic                          res_ready_o,
    input  sld_pkg::sld_token_t           tok_i,
    input  logic [sld_pkg::SLD_OP_W-1:0]  result_i,
    input  logic [sld_pkg::CHUNK_B-1:0]   result_mask_i,
    input  logic [sld_pkg::VMSK_W-1:0]    v0msk_i,
    output logic                          vreg_wr_en_o,
    output logic [4:0]                    vreg_wr_addr_o,
    output logic [sld_pkg::VREG_W-1:0]    vreg_wr_o,
    output logic [sld_pkg::VMSK_W-1:0]    vreg_wr_mask_o
);

    import sld_pkg::*;

    logic                wr_en_q;
    logic [4:0]          addr_q;
    logic [VREG_W-1:0]   vd_shift_q;
    logic [VMSK_W-1:0]   msk_shift_q;
    logic [VMSK_W-1:0]   static_q;
    logic [VMSK_W-1:0]   vl_q;
    logic [VMSK_W-1:0]   vl_mask;
    logic [VMSK_W-1:0]   v0_bytes;
    logic [8:0]          vl_bytes;

    // the write port never stalls
    assign res_ready_o = 1'b1;

    // tail mask and element to byte expansion of v0
    always_comb begin
        vl_bytes = {2'b00, tok_i.vl} << tok_i.vsew;
        for (int b = 0; b < VMSK_W; b++) begin
            vl_mask[b]  = 9'(b) < vl_bytes;
            v0_bytes[b] = v0msk_i[b >> tok_i.vsew];
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= res_valid_i & tok_i.last;
        end
    end

    // chunks enter at the top, the dummy first chunk falls out the bottom
    always_ff @(posedge clk_i) begin
        if (res_valid_i) begin
            vd_shift_q  <= {result_i, vd_shift_q[VREG_W-1:SLD_OP_W]};
            msk_shift_q <= {result_mask_i, msk_shift_q[VMSK_W-1:CHUNK_B]};
            if (tok_i.first) begin
                static_q <= tok_i.masked ? v0_bytes : {VMSK_W{1'b1}};
            end
            if (tok_i.last) begin
                addr_q <= tok_i.vd;
                vl_q   <= vl_mask;
            end
        end
    end

    assign vreg_wr_en_o   = wr_en_q;
    assign vreg_wr_addr_o = addr_q;
    assign vreg_wr_o      = vd_shift_q;
    assign vreg_wr_mask_o = wr_en_q ? (msk_shift_q & vl_q & static_q) : '0;

endmodule

// File: sld_align.sv
// slide byte alignment
// builds one result chunk from the operand pair and marks its valid bytes

`timescale 1ns/1ps

module sld_align (
    input  logic                          clk_i,
    input  logic                          async_rst_ni,
    input  logic                          op_valid_i,
    output logic                          op_ready_o,
    input  sld_pkg::sld_token_t           tok_i,
    input  logic [sld_pkg::SLD_OP_W-1:0]  op_low_i,
    input  logic [sld_pkg::SLD_OP_W-1:0]  op_high_i,
    output logic                          res_valid_o,
    input  logic                          res_ready_i,
    output sld_pkg::sld_token_t           tok_o,
    output logic [sld_pkg::SLD_OP_W-1:0]  result_o,
    output logic [sld_pkg::CHUNK_B-1:0]   result_mask_o
);

    import sld_pkg::*;

    typedef struct packed {
        sld_token_t          tok;
        logic [SLD_OP_W-1:0] result;
        logic [CHUNK_B-1:0]  mask;
    } res_pl_t;

    logic [2*SLD_OP_W-1:0] pair;
    logic                  low_ok;
    logic                  high_ok;
    res_pl_t               pl_d;
    res_pl_t               pl_q;

    assign pair = {op_high_i, op_low_i};

    // slide down writes zero fill, slide up skips bytes without a source
    assign low_ok  = (tok_i.mode == SLD_DOWN) | ((tok_i.store - 1'b1) < CNT_W'(CHUNKS));
    assign high_ok = (tok_i.mode == SLD_DOWN) | (tok_i.store < CNT_W'(CHUNKS));

    always_comb begin
        pl_d.tok = tok_i;
        for (int i = 0; i < CHUNK_B; i++) begin
            pl_d.result[i*8 +: 8] = pair[(int'(tok_i.shift) + i)*8 +: 8];
            pl_d.mask[i]          = (int'(tok_i.shift) + i < CHUNK_B) ? low_ok : high_ok;
        end
    end

    sld_stage_reg #(
        .payload_t (res_pl_t)
    ) res_stage_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (op_valid_i),
        .ready_o      (op_ready_o),
        .data_i       (pl_d),
        .valid_o      (res_valid_o),
        .ready_i      (res_ready_i),
        .data_o       (pl_q)
    );

    assign tok_o         = pl_q.tok;
    assign result_o      = pl_q.result;
    assign result_mask_o = pl_q.mask;

endmodule

// File: sld_operand.sv
// slide operand stage
// holds the source register and picks the chunk pair for each token

`timescale 1ns/1ps

module sld_operand (
    input  logic                          clk_i,
    input  logic                          async_rst_ni,
    input  logic                          tok_valid_i,
    output logic                          tok_ready_o,
    input  sld_pkg::sld_token_t           tok_i,
    input  logic [sld_pkg::VREG_W-1:0]    vreg_rd_i,
    input  logic [sld_pkg::VMSK_W-1:0]    vreg_mask_i,
    output logic                          op_valid_o,
    input  logic                          op_ready_i,
    output sld_pkg::sld_token_t           tok_o,
    output logic [sld_pkg::SLD_OP_W-1:0]  op_low_o,
    output logic [sld_pkg::SLD_OP_W-1:0]  op_high_o,
    output logic [sld_pkg::VMSK_W-1:0]    v0msk_o
);

    import sld_pkg::*;

    typedef struct packed {
        sld_token_t          tok;
        logic [SLD_OP_W-1:0] low;
        logic [SLD_OP_W-1:0] high;
    } op_pl_t;

    logic [VREG_W-1:0] src_q;
    logic [VREG_W-1:0] src;
    logic [VMSK_W-1:0] v0msk_q;
    logic [CNT_W-1:0]  low_idx;
    op_pl_t            pl_d;
    op_pl_t            pl_q;

    // first token reads the register file directly
    assign src     = tok_i.first ? vreg_rd_i : src_q;
    assign low_idx = tok_i.store - 1'b1;

    always_ff @(posedge clk_i) begin
        if (tok_valid_i & tok_ready_o & tok_i.first) begin
            src_q   <= vreg_rd_i;
            v0msk_q <= vreg_mask_i;
        end
    end

    // chunks outside the register read as zero
    always_comb begin
        pl_d.tok  = tok_i;
        pl_d.low  = '0;
        pl_d.high = '0;
        if (low_idx < CNT_W'(CHUNKS)) begin
            pl_d.low = src[low_idx[1:0]*SLD_OP_W +: SLD_OP_W];
        end
        if (tok_i.store < CNT_W'(CHUNKS)) begin
            pl_d.high = src[tok_i.store[1:0]*SLD_OP_W +: SLD_OP_W];
        end
    end

    sld_stage_reg #(
        .payload_t (op_pl_t)
    ) op_stage_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .valid_i      (tok_valid_i),
        .ready_o      (tok_ready_o),
        .data_i       (pl_d),
        .valid_o      (op_valid_o),
        .ready_i      (op_ready_i),
        .data_o       (pl_q)
    );

    assign tok_o     = pl_q.tok;
    assign op_low_o  = pl_q.low;
    assign op_high_o = pl_q.high;
    assign v0msk_o   = v0msk_q;

endmodule

// File: sld_ctrl.sv
// slide command control
// converts the slide amount into chunk offset and byte shift, issues tokens

`timescale 1ns/1ps

module sld_ctrl (
    input  logic                          clk_i,
    input  logic                          async_rst_ni,
    input  logic                          op_rdy_i,
    output logic                          op_ack_o,
    input  sld_pkg::sld_op_e              mode_i,
    input  sld_pkg::vsew_e                vsew_i,
    input  logic [sld_pkg::CFG_VL_W-1:0]  vl_i,
    input  logic                          masked_i,
    input  logic [31:0]                   rs1_i,
    input  logic [4:0]                    vs2_i,
    input  logic [4:0]                    vd_i,
    output logic                          tok_valid_o,
    input  logic                          tok_ready_i,
    output sld_pkg::sld_token_t           tok_o,
    output logic [4:0]                    vreg_rd_addr_o
);

    import sld_pkg::*;

    logic                busy_q;
    sld_token_t          tok_q;
    logic [4:0]          vs2_q;
    logic [3:0]          byte_slide;
    logic                sld_ok;
    logic [CNT_W-1:0]    store_init;
    logic                accept;

    // slide amount in bytes, valid only below VLMAX
    always_comb begin
        byte_slide = 4'(rs1_i << vsew_i);
        case (vsew_i)
            VSEW_8:  sld_ok = rs1_i[31:4] == '0;
            VSEW_16: sld_ok = rs1_i[31:3] == '0;
            default: sld_ok = rs1_i[31:2] == '0;
        endcase
    end

    // store counter start, it is the source chunk index of the high operand
    always_comb begin
        if (mode_i == SLD_UP) begin
            store_init = CNT_W'(0) - CNT_W'(byte_slide[3:2])
                         - CNT_W'(byte_slide[1:0] != '0);
        end else begin
            store_init = CNT_W'(byte_slide[3:2]);
        end
        if (~sld_ok) begin
            // overflow state, no chunk is in range
            store_init = {1'b1, {(CNT_W-1){1'b0}}};
        end
    end

    assign accept   = op_rdy_i & (~busy_q | (tok_q.last & tok_ready_i));
    assign op_ack_o = accept;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            busy_q <= 1'b0;
            tok_q  <= '0;
            vs2_q  <= '0;
        end else if (accept) begin
            busy_q       <= 1'b1;
            vs2_q        <= vs2_i;
            tok_q.chunk  <= '0;
            tok_q.store  <= store_init;
            tok_q.shift  <= (mode_i == SLD_UP) ? -byte_slide[1:0] : byte_slide[1:0];
            tok_q.first  <= 1'b1;
            tok_q.last   <= 1'b0;
            tok_q.mode   <= mode_i;
            tok_q.vsew   <= vsew_i;
            tok_q.vl     <= vl_i;
            tok_q.masked <= masked_i;
            tok_q.vd     <= vd_i;
        end else if (busy_q & tok_ready_i) begin
            busy_q      <= ~tok_q.last;
            tok_q.chunk <= tok_q.chunk + 1'b1;
            tok_q.store <= tok_q.store + 1'b1;
            tok_q.first <= 1'b0;
            tok_q.last  <= tok_q.chunk == CNT_W'(CHUNKS - 1);
        end
    end

    assign tok_valid_o    = busy_q;
    assign tok_o          = tok_q;
    assign vreg_rd_addr_o = vs2_q;

endmodule

// File: sld_stage_reg.sv
// slide pipeline register
// valid/ready handshake with a payload of any type

`timescale 1ns/1ps

module sld_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     async_rst_ni,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // stage takes a new token when empty or when the next stage drains it
    assign ready_o = ~valid_q | ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (~async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ready_o & valid_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

// File: sld_pkg.sv
// vector slide unit package
// shared widths, slide mode and element width types, pipeline token

package sld_pkg;

    // register and chunk geometry
    localparam int unsigned VREG_W   = 128;
    localparam int unsigned SLD_OP_W = 32;
    localparam int unsigned CHUNKS   = VREG_W / SLD_OP_W;
    localparam int unsigned VMSK_W   = VREG_W / 8;
    localparam int unsigned CHUNK_B  = SLD_OP_W / 8;

    // vl counts elements up to VLMAX at SEW 8
    localparam int unsigned CFG_VL_W = 7;

    // byte shift inside a chunk
    localparam int unsigned SHIFT_W  = $clog2(CHUNK_B);

    // chunk counter, upper bits hold the out of range / overflow state
    localparam int unsigned CNT_W    = 4;

    typedef enum logic {
        SLD_UP   = 1'b0,
        SLD_DOWN = 1'b1
    } sld_op_e;

    typedef enum logic [1:0] {
        VSEW_8  = 2'b00,
        VSEW_16 = 2'b01,
        VSEW_32 = 2'b10
    } vsew_e;

    // one token per chunk cycle
    typedef struct packed {
        logic [CNT_W-1:0]    chunk;
        logic [CNT_W-1:0]    store;
        logic [SHIFT_W-1:0]  shift;
        logic                first;
        logic                last;
        sld_op_e             mode;
        vsew_e               vsew;
        logic [CFG_VL_W-1:0] vl;
        logic                masked;
        logic [4:0]          vd;
    } sld_token_t;

endpackage
